// File: files.f
source/apbMapPkg.sv
source/i2cBusPkg.sv
source/apbRegs.sv
source/syncFifo.sv
source/i2cMaster.sv
source/apbI2cTop.sv
dv/i2cSlaveModel.sv
dv/apbI2cAssert.sv
dv/apbI2cTb.sv

// File: dv/apbI2cTb.sv
// Testbench of the APB I2C master
// APB driver, wired-AND I2C lines with a slave model, directed tests
`timescale 1ns/1ps
`default_nettype none

module apbI2cTb;

	localparam logic [6:0] slaveAddr = 7'h3A;
	// Nobody answers here
	localparam logic [6:0] otherAddr = 7'h15;
	localparam int readyLimit = 4;
	localparam int startLimit = 20;
	localparam int busyLimit = 10000;

	logic PCLK;
	logic PRESETn;
	logic PSELx;
	logic PENABLE;
	logic PWRITE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic INT_TX;
	logic INT_RX;
	logic sclOe;
	logic sdaOe;
	logic slaveScl;
	logic slaveSda;
	logic sclLine;
	logic sdaLine;
	logic [7:0] expBytes [32];

	// Pull-ups, any driver pulls low
	assign sclLine = !(sclOe === 1'b1 || slaveScl === 1'b1);
	assign sdaLine = !(sdaOe === 1'b1 || slaveSda === 1'b1);

	apbI2cTop dut (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSELx(PSELx), .PWRITE(PWRITE),
		.PENABLE(PENABLE), .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
		.PREADY(PREADY), .PSLVERR(PSLVERR), .INT_TX(INT_TX), .INT_RX(INT_RX),
		.sclOe(sclOe), .sdaOe(sdaOe), .sclIn(sclLine), .sdaIn(sdaLine)
	);

	i2cSlaveModel #(.ownAddr(slaveAddr)) slave (
		.clk(PCLK), .scl(sclLine), .sda(sdaLine), .sclDrive(slaveScl), .sdaDrive(slaveSda)
	);

	// 40 ns period
	always #20 PCLK = ~PCLK;

	////////////////////
	// Failure reporting and compares
	task automatic abortRun(input string line);
		$display("%s", line);
		$display("test failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic checkWord(input string what, input i2cBusPkg::txWord_t got,
		input i2cBusPkg::txWord_t exp);
		if (got !== exp)
			abortRun($sformatf("** Error at %0d ns: %s expected %h got %h", $time, what, exp, got));
	endtask

	task automatic checkByte(input string what, input i2cBusPkg::rxByte_t got,
		input i2cBusPkg::rxByte_t exp);
		if (got !== exp)
			abortRun($sformatf("** Error at %0d ns: %s expected %h got %h", $time, what, exp, got));
	endtask

	task automatic checkFlag(input string what, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("** Error at %0d ns: %s expected %b got %b", $time, what, exp, got));
	endtask

	////////////////////
	// APB zero-wait accesses, outputs sampled mid-cycle
	task automatic apbCycle(input logic write, input logic [31:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		int cycles;
		@(posedge PCLK);
		PSELx <= 1'b1;
		PENABLE <= 1'b0;
		PWRITE <= write;
		PADDR <= addr;
		PWDATA <= data;
		@(posedge PCLK);
		PENABLE <= 1'b1;
		@(negedge PCLK);
		cycles = 0;
		while (PREADY !== 1'b1)
		begin
			if (cycles == readyLimit)
				abortRun($sformatf("PREADY never rose for address %h", addr));
			else
			begin
				cycles++;
				@(negedge PCLK);
			end
		end
		rdata = PRDATA;
		err = PSLVERR;
		@(posedge PCLK);
		PSELx <= 1'b0;
		PENABLE <= 1'b0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		logic err;
		apbCycle(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input logic [31:0] addr, output logic [31:0] rdata, output logic err);
		apbCycle(1'b0, addr, 32'h0, rdata, err);
	endtask

	// Configuration word with the enable bit set
	function automatic logic [31:0] cfgWord(input logic readMode, input logic [6:0] addr,
		input logic [4:0] count);
		logic [31:0] w;
		w = '0;
		w[apbMapPkg::cfgEnableBit] = 1'b1;
		w[apbMapPkg::cfgReadBit] = readMode;
		w[apbMapPkg::cfgAddrMsb:apbMapPkg::cfgAddrLsb] = addr;
		w[apbMapPkg::cfgCountMsb:apbMapPkg::cfgCountLsb] = count;
		return w;
	endfunction

	// Busy rises after the start pulse, then falls after STOP
	task automatic waitTransfer();
		int cycles;
		cycles = 0;
		while (dut.busy !== 1'b1)
		begin
			if (cycles == startLimit)
				abortRun("Transfer never started, busy stayed low");
			else
			begin
				cycles++;
				@(negedge PCLK);
			end
		end
		cycles = 0;
		while (dut.busy !== 1'b0)
		begin
			if (cycles == busyLimit)
				abortRun("Transfer did not finish, busy stayed high");
			else
			begin
				cycles++;
				@(negedge PCLK);
			end
		end
	endtask

	////////////////////
	// Directed tests
	task automatic resetState();
		@(negedge PCLK);
		checkFlag("INT_TX after reset", INT_TX, 1'b1);
		checkFlag("INT_RX after reset", INT_RX, 1'b1);
		checkFlag("PSLVERR after reset", PSLVERR, 1'b0);
		checkFlag("SCL released after reset", sclOe, 1'b0);
		checkFlag("SDA released after reset", sdaOe, 1'b0);
	endtask

	task automatic writeTransfer(input int nWords);
		i2cBusPkg::txWord_t words [8];
		logic [31:0] rdata;
		logic err;
		slave.clearLog();
		for (int i = 0; i < nWords; i++)
		begin
			words[i] = $urandom;
			apbWrite(apbMapPkg::addrTxData, words[i]);
		end
		apbWrite(apbMapPkg::addrConfig, cfgWord(1'b0, slaveAddr, 5'd0));
		waitTransfer();
		checkByte("bytes seen by slave", 8'(slave.capCount), 8'(1 + 4 * nWords));
		checkByte("address byte", slave.capBytes[0], {slaveAddr, 1'b0});
		// Bytes on the bus go most significant first
		for (int i = 0; i < nWords; i++)
			checkWord("word on the bus", {slave.capBytes[4*i+1], slave.capBytes[4*i+2],
				slave.capBytes[4*i+3], slave.capBytes[4*i+4]}, words[i]);
		@(negedge PCLK);
		checkFlag("INT_TX after write", INT_TX, 1'b1);
		apbRead(apbMapPkg::addrConfig, rdata, err);
		checkFlag("PSLVERR after write", err, 1'b0);
	endtask

	task automatic readTransfer(input int count, input int expected);
		logic [31:0] rdata;
		logic err;
		for (int i = 0; i < 32; i++)
		begin
			expBytes[i] = 8'($urandom);
			slave.setResponse(i, expBytes[i]);
		end
		apbWrite(apbMapPkg::addrConfig, cfgWord(1'b1, slaveAddr, 5'(count)));
		waitTransfer();
		checkByte("bytes sent by slave", 8'(slave.patIdx), 8'(expected));
		apbRead(apbMapPkg::addrConfig, rdata, err);
		checkFlag("PSLVERR after read", err, 1'b0);
		// Each read returns the head and pops it
		for (int i = 0; i < expected; i++)
		begin
			apbRead(apbMapPkg::addrRxData, rdata, err);
			checkWord("RX data", rdata, {24'h0, expBytes[i]});
		end
		@(negedge PCLK);
		checkFlag("INT_RX after drain", INT_RX, 1'b1);
	endtask

	task automatic nackTransfer();
		logic [31:0] rdata;
		logic err;
		apbWrite(apbMapPkg::addrConfig, cfgWord(1'b1, otherAddr, 5'd1));
		waitTransfer();
		apbRead(apbMapPkg::addrConfig, rdata, err);
		checkFlag("PSLVERR after NACK", err, 1'b1);
		// Next good transfer clears the error
		writeTransfer(1);
	endtask

	task automatic stretchTimeout();
		logic [31:0] rdata;
		logic err;
		slave.setStretch(200);
		slave.clearLog();
		apbWrite(apbMapPkg::addrTimeout, 32'd50);
		apbWrite(apbMapPkg::addrTxData, $urandom);
		apbWrite(apbMapPkg::addrConfig, cfgWord(1'b0, slaveAddr, 5'd0));
		waitTransfer();
		apbRead(apbMapPkg::addrConfig, rdata, err);
		checkFlag("PSLVERR after stretch timeout", err, 1'b1);
		checkByte("bytes before timeout", 8'(slave.capCount), 8'd1);
		// Zero timeout waits out the same stretch
		apbWrite(apbMapPkg::addrTimeout, 32'd0);
		writeTransfer(1);
		slave.setStretch(0);
	endtask

	////////////////////
	initial
	begin
		PCLK = 1'b0;
		PRESETn = 1'b0;
		PSELx = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		// Seed the generator once
		void'($urandom(20));
		repeat (2) @(posedge PCLK);
		PRESETn <= 1'b1;
		resetState();
		writeTransfer(2);
		readTransfer(5, 5);
		nackTransfer();
		stretchTimeout();
		// Count above the depth, RX full ends the read
		readTransfer(12, i2cBusPkg::fifoDepth);
		if (dut.regs.apbChecks.failCount == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/apbI2cAssert.sv
// APB output checks of the register block
// Attached to apbRegs by bind
`timescale 1ns/1ps
`default_nettype none

module apbI2cAssert (
	input logic PCLK,
	input logic PRESETn,
	input logic PREADY,
	input logic PSLVERR,
	input logic txPush,
	input logic rxPop,
	input logic INT_TX,
	input logic INT_RX
);

	// Number of failed assertions so far
	int failCount = 0;

	// Error response only on a completed access
	errWithReady: assert property (@(posedge PCLK) disable iff (!PRESETn)
		PSLVERR |-> PREADY)
	else
	begin
		failCount++;
		$error("PSLVERR high without PREADY");
	end

	// A TX push leaves the FIFO holding data
	txPushClearsInt: assert property (@(posedge PCLK) disable iff (!PRESETn)
		txPush |=> !INT_TX)
	else
	begin
		failCount++;
		$error("INT_TX still high after a TX push");
	end

	// RX data is only popped while present
	rxPopNotEmpty: assert property (@(posedge PCLK) disable iff (!PRESETn)
		rxPop |-> !INT_RX)
	else
	begin
		failCount++;
		$error("rxPop while the RX FIFO is empty");
	end

endmodule

bind apbRegs apbI2cAssert apbChecks (
	.PCLK(PCLK),
	.PRESETn(PRESETn),
	.PREADY(PREADY),
	.PSLVERR(PSLVERR),
	.txPush(txPush),
	.rxPop(rxPop),
	.INT_TX(INT_TX),
	.INT_RX(INT_RX)
);

`default_nettype wire

// File: dv/i2cSlaveModel.sv
// Behavioral I2C slave for the testbench
// Fixed address, byte log, read response pattern and optional SCL stretch
`timescale 1ns/1ps
`default_nettype none

module i2cSlaveModel #(
	parameter logic [6:0] ownAddr = 7'h3A
) (
	input  logic clk,
	input  logic scl,
	input  logic sda,
	output logic sclDrive,
	output logic sdaDrive
);

	typedef enum {mIdle, mAddr, mWrite, mRead} mode_t;

	mode_t mode;
	logic active;
	// -1 until the START's own SCL fall, 8 is the ACK bit
	int bitPos;
	logic [7:0] shiftIn;
	logic [7:0] outByte;
	logic masterNack;
	logic stretched;
	int stretchCycles;
	int stretchLeft;
	// Address byte and written bytes, in bus order
	logic [7:0] capBytes [64];
	int capCount;
	// Bytes returned in read mode
	logic [7:0] respPattern [32];
	int patIdx;

	initial
	begin
		sclDrive = 1'b0;
		sdaDrive = 1'b0;
		active = 1'b0;
		mode = mIdle;
		bitPos = 0;
		shiftIn = '0;
		outByte = '0;
		masterNack = 1'b0;
		stretched = 1'b0;
		stretchCycles = 0;
		stretchLeft = 0;
		capCount = 0;
		patIdx = 0;
	end

	task automatic clearLog();
		capCount = 0;
	endtask

	task automatic setResponse(input int idx, input logic [7:0] value);
		respPattern[idx] = value;
	endtask

	task automatic setStretch(input int cycles);
		stretchCycles = cycles;
	endtask

	////////////////////
	// START, SDA falls while SCL is high
	always @(negedge sda)
	begin
		if (scl === 1'b1)
		begin
			active = 1'b1;
			mode = mAddr;
			bitPos = -1;
			patIdx = 0;
			stretched = 1'b0;
			masterNack = 1'b0;
		end
	end

	// STOP, SDA rises while SCL is high
	always @(posedge sda)
	begin
		if (scl === 1'b1 && active)
		begin
			active = 1'b0;
			mode = mIdle;
			sdaDrive = 1'b0;
		end
	end

	////////////////////
	// Sample on the rising SCL edge
	always @(posedge scl)
	begin
		if (active && bitPos >= 0 && bitPos < 8 && mode != mRead)
			shiftIn = {shiftIn[6:0], sda};
		else if (active && bitPos == 8 && mode == mRead)
			masterNack = sda;
	end

	// Change SDA only while SCL is low
	always @(negedge scl)
	begin
		if (active)
		begin
			if (bitPos < 7)
			begin
				bitPos = bitPos + 1;
				if (mode == mRead)
					sdaDrive = !outByte[7-bitPos];
			end
			else if (bitPos == 7)
			begin
				bitPos = 8;
				sdaDrive = 1'b0;
				if (mode == mAddr && shiftIn[7:1] == ownAddr)
				begin
					// Own address, ACK it and pick the direction
					capBytes[capCount] = shiftIn;
					capCount = capCount + 1;
					sdaDrive = 1'b1;
					mode = shiftIn[0] ? mRead : mWrite;
				end
				else if (mode == mAddr)
					mode = mIdle;
				else if (mode == mWrite)
				begin
					capBytes[capCount] = shiftIn;
					capCount = capCount + 1;
					sdaDrive = 1'b1;
				end
			end
			else
			begin
				// ACK bit over, next byte starts
				bitPos = 0;
				sdaDrive = 1'b0;
				if (mode == mRead && !masterNack)
				begin
					outByte = respPattern[patIdx];
					patIdx = patIdx + 1;
					sdaDrive = !outByte[7];
				end
				else if (mode == mRead)
					mode = mIdle;
				// One stretch per transfer, after the address ACK
				if (!stretched && stretchCycles > 0)
				begin
					stretched = 1'b1;
					stretchLeft = stretchCycles;
					sclDrive = 1'b1;
				end
			end
		end
	end

	// Stretch counter, away from the rising PCLK edge
	always @(negedge clk)
	begin
		if (stretchLeft > 0)
		begin
			stretchLeft = stretchLeft - 1;
			if (stretchLeft == 0)
				sclDrive = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/apbI2cTop.sv
// APB to I2C master top level
// Register block, TX and RX FIFOs and the bit engine
`timescale 1ns/1ps
`default_nettype none

module apbI2cTop (
	input  logic        PCLK,
	input  logic        PRESETn,
	input  logic        PSELx,
	input  logic        PWRITE,
	input  logic        PENABLE,
	input  logic [31:0] PADDR,
	input  logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic        PREADY,
	output logic        PSLVERR,
	output logic        INT_TX,
	output logic        INT_RX,
	output logic        sclOe,
	output logic        sdaOe,
	input  logic        sclIn,
	input  logic        sdaIn
);

	// Register block to FIFOs and engine
	logic txPush;
	logic rxPop;
	i2cBusPkg::txWord_t txWdata;
	apbMapPkg::cfgReg_t cfgReg;
	apbMapPkg::cfgReg_t timeoutReg;
	logic startPulse;

	// FIFO status and heads
	i2cBusPkg::txWord_t txData;
	i2cBusPkg::rxByte_t rxData;
	logic txEmpty;
	logic rxEmpty;
	logic rxFull;

	// Engine side
	logic txPop;
	logic rxPush;
	i2cBusPkg::rxByte_t rxWdata;
	// Transfer in progress, for monitoring
	logic busy;
	logic error;

	////////////////////
	apbRegs regs (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSELx(PSELx), .PWRITE(PWRITE),
		.PENABLE(PENABLE), .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
		.PREADY(PREADY), .PSLVERR(PSLVERR), .rxData(rxData), .rxEmpty(rxEmpty),
		.txEmpty(txEmpty), .error(error), .txPush(txPush), .rxPop(rxPop),
		.txWdata(txWdata), .cfgReg(cfgReg), .timeoutReg(timeoutReg),
		.startPulse(startPulse), .INT_TX(INT_TX), .INT_RX(INT_RX)
	);

	// Full flag unused, a push on full is dropped inside
	syncFifo #(.payload_t(i2cBusPkg::txWord_t)) txFifo (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(txPush), .pop(txPop),
		.wdata(txWdata), .rdata(txData), .full(), .empty(txEmpty)
	);

	syncFifo #(.payload_t(i2cBusPkg::rxByte_t)) rxFifo (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(rxPush), .pop(rxPop),
		.wdata(rxWdata), .rdata(rxData), .full(rxFull), .empty(rxEmpty)
	);

	i2cMaster engine (
		.PCLK(PCLK), .PRESETn(PRESETn), .startPulse(startPulse), .cfgReg(cfgReg),
		.timeoutReg(timeoutReg), .txData(txData), .txEmpty(txEmpty), .rxFull(rxFull),
		.txPop(txPop), .rxPush(rxPush), .rxWdata(rxWdata), .busy(busy), .error(error),
		.sclOe(sclOe), .sdaOe(sdaOe), .sclIn(sclIn), .sdaIn(sdaIn)
	);

endmodule

`default_nettype wire

// File: source/i2cMaster.sv
// Bit level I2C master engine
// START, address, data bytes with ACK, STOP, clock stretch timeout
`timescale 1ns/1ps
`default_nettype none

module i2cMaster (
	input  logic                PCLK,
	input  logic                PRESETn,
	input  logic                startPulse,
	input  apbMapPkg::cfgReg_t  cfgReg,
	input  apbMapPkg::cfgReg_t  timeoutReg,
	input  i2cBusPkg::txWord_t  txData,
	input  logic                txEmpty,
	input  logic                rxFull,
	output logic                txPop,
	output logic                rxPush,
	output i2cBusPkg::rxByte_t  rxWdata,
	output logic                busy,
	output logic                error,
	output logic                sclOe,
	output logic                sdaOe,
	input  logic                sclIn,
	input  logic                sdaIn
);

	typedef enum logic [2:0] {sIdle, sStart, sAddr, sWrite, sRead, sAck, sStop} state_t;

	state_t state;
	logic [1:0] ph;
	logic [$clog2(i2cBusPkg::sclQuarter)-1:0] qCnt;
	logic [2:0] bitCnt;
	logic [1:0] byteIdx;
	i2cBusPkg::rxByte_t shiftReg;
	i2cBusPkg::txWord_t wordReg;
	logic readMode;
	logic fromAddr;
	logic nackReg;
	logic [apbMapPkg::cfgCountMsb-apbMapPkg::cfgCountLsb:0] rxLeft;
	apbMapPkg::cfgReg_t timeoutLat;
	apbMapPkg::cfgReg_t stretchCnt;
	logic stretching;
	logic stepPhase;
	logic timeoutHit;
	logic ackDrive;
	logic nackNext;

	////////////////////
	// Pacing and status
	// Slave holds SCL low after release
	assign stretching = (state != sIdle) && !sclOe && !sclIn;
	// Quarter ends, frozen while stretched
	assign stepPhase = (qCnt == i2cBusPkg::sclQuarter - 1) && !stretching;
	// STOP always waits for SCL, no timeout there
	assign timeoutHit = (state != sStop) && (timeoutLat != '0) && (stretchCnt == timeoutLat);
	// Master drives ACK only after read data bytes
	assign ackDrive = readMode && !fromAddr;
	// Last byte or full RX FIFO ends the read
	assign nackNext = (rxLeft == '0) || rxFull;
	assign busy = (state != sIdle);

	// SCL low in the first half of each bit
	always_comb
	begin
		case (state)
			sStart: sclOe = (ph == 2'd3);
			sAddr, sWrite, sRead, sAck: sclOe = (ph < 2'd2);
			sStop: sclOe = (ph < 2'd2);
			default: sclOe = 1'b0;
		endcase
	end

	////////////////////
	// Main FSM, SDA only changes at the end of quarter 0 or 2
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state <= sIdle;
			ph <= '0;
			qCnt <= '0;
			bitCnt <= '0;
			byteIdx <= '0;
			readMode <= 1'b0;
			fromAddr <= 1'b0;
			nackReg <= 1'b0;
			rxLeft <= '0;
			timeoutLat <= '0;
			stretchCnt <= '0;
			sdaOe <= 1'b0;
			error <= 1'b0;
			txPop <= 1'b0;
			rxPush <= 1'b0;
		end
		else
		begin
			txPop <= 1'b0;
			rxPush <= 1'b0;
			// Stretch counter saturates
			if (!stretching)
				stretchCnt <= '0;
			else if (stretchCnt != '1)
				stretchCnt <= stretchCnt + 1'b1;
			// Quarter counter
			if (stepPhase)
			begin
				qCnt <= '0;
				ph <= ph + 1'b1;
			end
			else if (!stretching)
			begin
				qCnt <= qCnt + 1'b1;
			end
			case (state)
				sIdle:
				begin
					// Start while busy never reaches here
					if (startPulse)
					begin
						state <= sStart;
						ph <= '0;
						qCnt <= '0;
						error <= 1'b0;
						sdaOe <= 1'b0;
						readMode <= cfgReg[apbMapPkg::cfgReadBit];
						rxLeft <= cfgReg[apbMapPkg::cfgCountMsb:apbMapPkg::cfgCountLsb];
						timeoutLat <= timeoutReg;
						shiftReg <= {cfgReg[apbMapPkg::cfgAddrMsb:apbMapPkg::cfgAddrLsb],
							cfgReg[apbMapPkg::cfgReadBit]};
					end
				end
				sStart:
				begin
					// SDA falls while SCL is high
					if (stepPhase && ph == 2'd0)
						sdaOe <= 1'b1;
					if (stepPhase && ph == 2'd3)
					begin
						state <= sAddr;
						bitCnt <= '0;
						fromAddr <= 1'b1;
					end
				end
				sAddr, sWrite:
				begin
					// MSB first, pull low for a zero
					if (stepPhase && ph == 2'd0)
						sdaOe <= !shiftReg[7];
					if (stepPhase && ph == 2'd3)
					begin
						shiftReg <= {shiftReg[6:0], 1'b0};
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
							state <= sAck;
					end
				end
				sRead:
				begin
					if (stepPhase && ph == 2'd0)
						sdaOe <= 1'b0;
					// Sample once SCL is really high
					if (stepPhase && ph == 2'd2)
						shiftReg <= {shiftReg[6:0], sdaIn};
					if (stepPhase && ph == 2'd3)
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
						begin
							state <= sAck;
							rxPush <= 1'b1;
							rxWdata <= shiftReg;
							if (rxLeft != '0)
								rxLeft <= rxLeft - 1'b1;
						end
					end
				end
				sAck:
				begin
					// rxFull already reflects this byte's push here
					if (stepPhase && ph == 2'd0)
					begin
						nackReg <= ackDrive ? nackNext : nackReg;
						sdaOe <= ackDrive && !nackNext;
					end
					if (stepPhase && ph == 2'd2 && !ackDrive)
						nackReg <= sdaIn;
					if (stepPhase && ph == 2'd3)
					begin
						fromAddr <= 1'b0;
						bitCnt <= '0;
						if (nackReg)
						begin
							// Slave NACK is an error, own NACK is a normal end
							state <= sStop;
							if (!ackDrive)
								error <= 1'b1;
						end
						else if (readMode)
						begin
							state <= sRead;
						end
						else if (fromAddr || byteIdx == 2'd3)
						begin
							// Next word or finish
							if (txEmpty)
							begin
								state <= sStop;
							end
							else
							begin
								state <= sWrite;
								wordReg <= txData;
								shiftReg <= txData[31:24];
								byteIdx <= '0;
								txPop <= 1'b1;
							end
						end
						else
						begin
							state <= sWrite;
							wordReg <= {wordReg[23:0], 8'h00};
							shiftReg <= wordReg[23:16];
							byteIdx <= byteIdx + 1'b1;
						end
					end
				end
				sStop:
				begin
					// SDA low under low SCL, then rises while SCL is high
					if (stepPhase && ph == 2'd0)
						sdaOe <= 1'b1;
					if (stepPhase && ph == 2'd2)
						sdaOe <= 1'b0;
					if (stepPhase && ph == 2'd3)
						state <= sIdle;
				end
				default: state <= sIdle;
			endcase
			// Stretch too long, abort with error
			if (timeoutHit)
			begin
				state <= sStop;
				ph <= '0;
				qCnt <= '0;
				stretchCnt <= '0;
				error <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/syncFifo.sv
// Synchronous FIFO on PCLK with the payload set by a type parameter
// Head is always visible on rdata
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
	parameter type payload_t = i2cBusPkg::rxByte_t
) (
	input  logic     PCLK,
	input  logic     PRESETn,
	input  logic     push,
	input  logic     pop,
	input  payload_t wdata,
	output payload_t rdata,
	output logic     full,
	output logic     empty
);

	payload_t mem [i2cBusPkg::fifoDepth];
	logic [$clog2(i2cBusPkg::fifoDepth)-1:0] wrPtr;
	logic [$clog2(i2cBusPkg::fifoDepth)-1:0] rdPtr;
	logic [$clog2(i2cBusPkg::fifoDepth+1)-1:0] count;
	logic doPush;
	logic doPop;

	// Push on full and pop on empty are dropped
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	assign full = (count == i2cBusPkg::fifoDepth);
	assign empty = (count == '0);
	assign rdata = mem[rdPtr];

	////////////////////
	// Storage
	always_ff @(posedge PCLK)
	begin
		if (doPush)
		begin
			mem[wrPtr] <= wdata;
		end
	end

	// Pointers wrap at the depth
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
			begin
				wrPtr <= (wrPtr == i2cBusPkg::fifoDepth - 1) ? '0 : wrPtr + 1'b1;
			end
			if (doPop)
			begin
				rdPtr <= (rdPtr == i2cBusPkg::fifoDepth - 1) ? '0 : rdPtr + 1'b1;
			end
			// Push and pop together keep the count
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: source/apbRegs.sv
// APB slave register block of the I2C master
// Decodes accesses into FIFO strobes and holds configuration and timeout
`timescale 1ns/1ps
`default_nettype none

module apbRegs (
	input  logic                PCLK,
	input  logic                PRESETn,
	input  logic                PSELx,
	input  logic                PWRITE,
	input  logic                PENABLE,
	input  logic [31:0]         PADDR,
	input  logic [31:0]         PWDATA,
	output logic [31:0]         PRDATA,
	output logic                PREADY,
	output logic                PSLVERR,
	input  i2cBusPkg::rxByte_t  rxData,
	input  logic                rxEmpty,
	input  logic                txEmpty,
	input  logic                error,
	output logic                txPush,
	output logic                rxPop,
	output i2cBusPkg::txWord_t  txWdata,
	output apbMapPkg::cfgReg_t  cfgReg,
	output apbMapPkg::cfgReg_t  timeoutReg,
	output logic                startPulse,
	output logic                INT_TX,
	output logic                INT_RX
);

	logic accessPhase;
	logic addrHit;
	logic cfgWrite;
	logic toutWrite;

	////////////////////
	// Address decode
	assign accessPhase = PSELx && PENABLE;
	assign addrHit = (PADDR == apbMapPkg::addrTxData) || (PADDR == apbMapPkg::addrRxData) ||
		(PADDR == apbMapPkg::addrConfig) || (PADDR == apbMapPkg::addrTimeout);

	// Zero-wait, only mapped words complete
	assign PREADY = accessPhase && addrHit;

	// FIFO strobes, one per access phase
	assign txPush = accessPhase && PWRITE && (PADDR == apbMapPkg::addrTxData);
	assign rxPop = accessPhase && !PWRITE && (PADDR == apbMapPkg::addrRxData);
	assign txWdata = PWDATA;

	// RX head shown directly, popped by the same read
	assign PRDATA = 32'(rxData);

	// Engine error reported on any access
	assign PSLVERR = accessPhase && error;

	// Interrupts are the FIFO empty levels
	assign INT_TX = txEmpty;
	assign INT_RX = rxEmpty;

	assign cfgWrite = accessPhase && PWRITE && (PADDR == apbMapPkg::addrConfig);
	assign toutWrite = accessPhase && PWRITE && (PADDR == apbMapPkg::addrTimeout);

	////////////////////
	// Configuration and timeout registers
	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfgReg <= '0;
			timeoutReg <= '0;
			startPulse <= 1'b0;
		end
		else
		begin
			if (cfgWrite)
			begin
				cfgReg <= PWDATA[apbMapPkg::regWidth-1:0];
			end
			if (toutWrite)
			begin
				timeoutReg <= PWDATA[apbMapPkg::regWidth-1:0];
			end
			// Start goes out together with the new configuration
			startPulse <= cfgWrite && PWDATA[apbMapPkg::cfgEnableBit];
		end
	end

endmodule

`default_nettype wire

// File: source/i2cBusPkg.sv
// I2C side definitions
// FIFO payload types, FIFO depth and bit timing
`default_nettype none

package i2cBusPkg;

	// TX FIFO word, sent as four bytes
	// Most significant byte goes out first
	typedef logic [31:0] txWord_t;

	// RX FIFO byte
	// Zero-extended onto PRDATA
	typedef logic [7:0] rxByte_t;

	// Entries per FIFO
	localparam int fifoDepth = 8;

	// PCLK cycles per quarter SCL period
	localparam int sclQuarter = 4;

endpackage

`default_nettype wire

// File: source/apbMapPkg.sv
// APB register map of the I2C master
// Word addresses, register width and configuration field positions
`default_nettype none

package apbMapPkg;

	////////////////////
	// Register addresses, one 32-bit word each
	localparam logic [31:0] addrTxData  = 32'd0;
	localparam logic [31:0] addrRxData  = 32'd4;
	localparam logic [31:0] addrConfig  = 32'd8;
	localparam logic [31:0] addrTimeout = 32'd12;

	// Width of configuration and timeout registers
	localparam int regWidth = 14;

	////////////////////
	// Write with this bit set starts a transfer
	localparam int cfgEnableBit = 0;
	// Read mode when set
	localparam int cfgReadBit = 1;
	// Seven bit slave address
	localparam int cfgAddrLsb = 2;
	localparam int cfgAddrMsb = 8;
	// Read byte count, 1 to 31
	localparam int cfgCountLsb = 9;
	localparam int cfgCountMsb = 13;

	typedef logic [regWidth-1:0] cfgReg_t;

endpackage

`default_nettype wire
